//--- board_fetch.sv
`timescale 1ns/10ps

module board_fetch
   import life_render_pkg::*;
(
   input  logic                    clk_in,
   input  logic                    rst_in,
   input  raster_t                 raster,
   input  pos_t                    view_x,
   input  pos_t                    view_y,
   input  board_word_t             data_in,
   output logic [LOG_MAX_ADDR-1:0] addr_out,
   output raster_t                 fetched_raster,
   output logic                    alive
);

   // blanked slot with inactive syncs, held while in reset
   localparam raster_t IDLE_RASTER = '{
      hcount: '0,
      vcount: '0,
      hsync: 1'b1,
      vsync: 1'b1,
      blank: 1'b1
   };

   typedef logic [LOG_WORD_SIZE-1:0] bit_idx_t;

   pos_t     board_x;
   pos_t     board_y;
   int       word_addr;
   bit_idx_t col_d1;
   bit_idx_t col_d2;
   raster_t  raster_d1;
   raster_t  raster_d2;
   raster_t  raster_d3;

   // pixel to board cell, wraps modulo board size
   always_comb begin
      board_x = view_x + pos_t'(raster.hcount >> LOG_CELL_SIZE);
      board_y = view_y + pos_t'(raster.vcount >> LOG_CELL_SIZE);
      word_addr = board_y * WORDS_PER_ROW + (board_x >> LOG_WORD_SIZE);
   end

   ////////////////////
   // pipeline
   ////////////////////

   // stage 1 address, stage 2 word back, stage 3 cell bit
   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         addr_out <= '0;
         alive <= 1'b0;
         raster_d1 <= IDLE_RASTER;
         raster_d2 <= IDLE_RASTER;
         raster_d3 <= IDLE_RASTER;
      end else begin
         addr_out <= LOG_MAX_ADDR'(word_addr);
         // msb of the word is the leftmost cell
         alive <= data_in[WORD_SIZE - 1 - col_d2];
         raster_d1 <= raster;
         raster_d2 <= raster_d1;
         raster_d3 <= raster_d2;
      end
   end

   // bit index waits out the memory latency
   always_ff @(posedge clk_in) begin
      col_d1 <= board_x[LOG_WORD_SIZE-1:0];
      col_d2 <= col_d1;
   end

   assign fetched_raster = raster_d3;

   // full word address before it is cut to the bus width
   a_addr_range: assert property (@(posedge clk_in) disable iff (rst_in)
      word_addr < BOARD_SIZE * WORDS_PER_ROW);

endmodule

//--- cursor_draw.sv
`timescale 1ns/10ps

module cursor_draw
   import life_render_pkg::*;
(
   input  raster_t fetched_raster,
   input  pos_t    view_x,
   input  pos_t    view_y,
   input  pos_t    cursor_x,
   input  pos_t    cursor_y,
   output logic    cursor_hit
);

   pos_t    cur_vx;
   pos_t    cur_vy;
   hcount_t x_lo;
   hcount_t x_hi;
   vcount_t y_lo;
   vcount_t y_hi;
   logic    in_x;
   logic    in_y;
   logic    on_x_side;
   logic    on_y_side;

   always_comb begin
      // cursor cell relative to the view, wraps around the board
      cur_vx = cursor_x - view_x;
      cur_vy = cursor_y - view_y;

      // pixel square of that cell
      x_lo = hcount_t'(cur_vx) << LOG_CELL_SIZE;
      x_hi = x_lo + hcount_t'(CELL_SIZE - 1);
      y_lo = vcount_t'(cur_vy) << LOG_CELL_SIZE;
      y_hi = y_lo + vcount_t'(CELL_SIZE - 1);

      in_x = (fetched_raster.hcount >= x_lo) && (fetched_raster.hcount <= x_hi);
      in_y = (fetched_raster.vcount >= y_lo) && (fetched_raster.vcount <= y_hi);

      // first or last column and row of the square
      on_x_side = (fetched_raster.hcount == x_lo) || (fetched_raster.hcount == x_hi);
      on_y_side = (fetched_raster.vcount == y_lo) || (fetched_raster.vcount == y_hi);

      cursor_hit = in_x && in_y && (on_x_side || on_y_side);
   end

endmodule

//--- filelist.f
life_render_pkg.sv
vga_timing.sv
board_fetch.sv
cursor_draw.sv
pixel_mixer.sv
renderer.sv
tb_board_mem.sv
tb_renderer.sv

//--- life_render_pkg.sv
package life_render_pkg;

   ////////////////////
   // board geometry
   ////////////////////

   // cells packed per memory word
   localparam int WORD_SIZE = 16;
   localparam int LOG_WORD_SIZE = 4;

   // square board, wraps on both axes
   localparam int BOARD_SIZE = 64;
   localparam int LOG_BOARD_SIZE = 6;
   localparam int WORDS_PER_ROW = BOARD_SIZE / WORD_SIZE;
   localparam int LOG_MAX_ADDR = 8;

   // screen pixels per cell side
   localparam int CELL_SIZE = 8;
   localparam int LOG_CELL_SIZE = 3;

   // visible window onto the board
   localparam int VIEW_SIZE = 16;
   localparam int VIEW_PIX = VIEW_SIZE * CELL_SIZE;

   ////////////////////
   // types
   ////////////////////

   typedef logic [LOG_BOARD_SIZE-1:0] pos_t;
   typedef logic [10:0] hcount_t;
   typedef logic [9:0] vcount_t;
   typedef logic [WORD_SIZE-1:0] board_word_t;

   typedef struct packed {
      logic [3:0] r;
      logic [3:0] g;
      logic [3:0] b;
   } rgb_t;

   // one pixel slot of the raster
   typedef struct packed {
      hcount_t hcount;
      vcount_t vcount;
      logic    hsync;
      logic    vsync;
      logic    blank;
   } raster_t;

   ////////////////////
   // layer colours
   ////////////////////

   localparam rgb_t CELL_COLOR = 12'h0F0;
   localparam rgb_t CURSOR_COLOR = 12'hF00;
   localparam rgb_t FENCE_COLOR = 12'hFFF;

endpackage

//--- pixel_mixer.sv
`timescale 1ns/10ps

module pixel_mixer
   import life_render_pkg::*;
#(
   parameter int DISPLAY_HEIGHT = 480
) (
   input  logic    clk_in,
   input  logic    rst_in,
   input  raster_t fetched_raster,
   input  logic    alive,
   input  logic    cursor_hit,
   output rgb_t    pix_out,
   output logic    hsync_out,
   output logic    vsync_out,
   output logic    done_out
);

   // fence column at the view edge, line across the right half
   localparam hcount_t FENCE_COL = hcount_t'(VIEW_PIX);
   localparam vcount_t FENCE_ROW = vcount_t'(DISPLAY_HEIGHT / 2);

   logic in_view;
   logic on_fence;
   rgb_t cell_pix;
   rgb_t fence_pix;
   rgb_t cursor_pix;
   rgb_t mixed_pix;

   ////////////////////
   // layers
   ////////////////////

   always_comb begin
      in_view = (fetched_raster.hcount < hcount_t'(VIEW_PIX))
                && (fetched_raster.vcount < vcount_t'(VIEW_PIX));

      on_fence = (fetched_raster.hcount == FENCE_COL)
                 || ((fetched_raster.hcount > FENCE_COL)
                     && (fetched_raster.vcount == FENCE_ROW));

      cell_pix = (alive && in_view) ? CELL_COLOR : '0;
      fence_pix = on_fence ? FENCE_COLOR : '0;
      cursor_pix = cursor_hit ? CURSOR_COLOR : '0;

      // layers overlap by OR per channel
      mixed_pix = cell_pix | fence_pix | cursor_pix;
   end

   ////////////////////
   // output register
   ////////////////////

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         pix_out <= '0;
         hsync_out <= 1'b1;
         vsync_out <= 1'b1;
         done_out <= 1'b1;
      end else begin
         pix_out <= fetched_raster.blank ? '0 : mixed_pix;
         // syncs already active low
         hsync_out <= fetched_raster.hsync;
         vsync_out <= fetched_raster.vsync;
         done_out <= (fetched_raster.vcount >= vcount_t'(DISPLAY_HEIGHT));
      end
   end

   // sync pulses sit inside blanking, so they leave with a black pixel
   a_blank_black: assert property (@(posedge clk_in) disable iff (rst_in)
      (!hsync_out || !vsync_out) |-> (pix_out == '0));

endmodule

//--- renderer.sv
`timescale 1ns/10ps

module renderer
   import life_render_pkg::*;
#(
   parameter int DISPLAY_WIDTH = 640,
   parameter int DISPLAY_HEIGHT = 480,
   parameter int H_FP = 16,
   parameter int H_SYNC = 96,
   parameter int H_BP = 48,
   parameter int V_FP = 11,
   parameter int V_SYNC = 2,
   parameter int V_BP = 31
) (
   input  logic                    clk_in,
   input  logic                    rst_in,
   input  board_word_t             data_in,
   input  pos_t                    view_x,
   input  pos_t                    view_y,
   input  pos_t                    cursor_x,
   input  pos_t                    cursor_y,
   output logic [LOG_MAX_ADDR-1:0] addr_out,
   output rgb_t                    pix_out,
   output logic                    hsync_out,
   output logic                    vsync_out,
   output logic                    done_out
);

   raster_t raster;
   raster_t fetched_raster;
   logic    frame_end;
   logic    alive;
   logic    cursor_hit;
   pos_t    view_x_q;
   pos_t    view_y_q;
   pos_t    cursor_x_q;
   pos_t    cursor_y_q;

   vga_timing #(
      .DISPLAY_WIDTH(DISPLAY_WIDTH),
      .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
      .H_FP(H_FP),
      .H_SYNC(H_SYNC),
      .H_BP(H_BP),
      .V_FP(V_FP),
      .V_SYNC(V_SYNC),
      .V_BP(V_BP)
   ) i_timing (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .raster(raster),
      .frame_end(frame_end)
   );

   // view and cursor only change between frames
   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         view_x_q <= '0;
         view_y_q <= '0;
         cursor_x_q <= '0;
         cursor_y_q <= '0;
      end else if (frame_end) begin
         view_x_q <= view_x;
         view_y_q <= view_y;
         cursor_x_q <= cursor_x;
         cursor_y_q <= cursor_y;
      end
   end

   board_fetch i_fetch (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .raster(raster),
      .view_x(view_x_q),
      .view_y(view_y_q),
      .data_in(data_in),
      .addr_out(addr_out),
      .fetched_raster(fetched_raster),
      .alive(alive)
   );

   cursor_draw i_cursor (
      .fetched_raster(fetched_raster),
      .view_x(view_x_q),
      .view_y(view_y_q),
      .cursor_x(cursor_x_q),
      .cursor_y(cursor_y_q),
      .cursor_hit(cursor_hit)
   );

   pixel_mixer #(
      .DISPLAY_HEIGHT(DISPLAY_HEIGHT)
   ) i_mixer (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .fetched_raster(fetched_raster),
      .alive(alive),
      .cursor_hit(cursor_hit),
      .pix_out(pix_out),
      .hsync_out(hsync_out),
      .vsync_out(vsync_out),
      .done_out(done_out)
   );

endmodule

//--- run_sim.sh
#!/bin/sh
# build and run the renderer testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_renderer -f filelist.f
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

sim_output=$(./obj_dir/Vtb_renderer)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_output" | grep -q "ALL TESTS PASSED"; then
   exit 0
fi
exit 1

//--- tb_board_mem.sv
`timescale 1ns/10ps

module tb_board_mem
   import life_render_pkg::*;
#(
   parameter int DEPTH = 256,
   parameter int SEED = 1
) (
   input  logic                    clk_in,
   input  logic [LOG_MAX_ADDR-1:0] addr,
   output board_word_t             data
);

   board_word_t mem [DEPTH];
   board_word_t rd_word = '0;
   int          seed;

   // random board, one word per address
   initial begin
      seed = SEED;
      for (int i = 0; i < DEPTH; i++) begin
         mem[i] = board_word_t'($random(seed));
      end
   end

   // synchronous read, one cycle latency
   always @(posedge clk_in) begin
      rd_word <= mem[addr];
   end

   assign data = rd_word;

endmodule

//--- tb_renderer.sv
`timescale 1ns/10ps

module tb_renderer
   import life_render_pkg::*;
();

   // small raster so four frames run quickly
   localparam int DISPLAY_WIDTH = 160;
   localparam int H_FP = 4;
   localparam int H_SYNC = 8;
   localparam int H_BP = 4;
   localparam int DISPLAY_HEIGHT = 96;
   localparam int V_FP = 2;
   localparam int V_SYNC = 2;
   localparam int V_BP = 2;

   localparam int H_TOTAL = DISPLAY_WIDTH + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL = DISPLAY_HEIGHT + V_FP + V_SYNC + V_BP;
   localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
   localparam int PIPE_DEPTH = 4;
   localparam int CYCLE_LIMIT = 4 * FRAME_CYCLES + 500;
   localparam int MEM_SEED = 32'h1c881da3;

   typedef struct packed {
      hcount_t                 h;
      vcount_t                 v;
      logic [LOG_MAX_ADDR-1:0] addr;
      rgb_t                    pix;
      logic                    hsync;
      logic                    vsync;
      logic                    done;
   } expect_t;

   logic                    clk_in;
   logic                    rst_in;
   board_word_t             data_in;
   pos_t                    view_x;
   pos_t                    view_y;
   pos_t                    cursor_x;
   pos_t                    cursor_y;
   logic [LOG_MAX_ADDR-1:0] addr_out;
   rgb_t                    pix_out;
   logic                    hsync_out;
   logic                    vsync_out;
   logic                    done_out;

   // reference raster and frame latch
   int      ref_h;
   int      ref_v;
   pos_t    ref_vx;
   pos_t    ref_vy;
   pos_t    ref_cx;
   pos_t    ref_cy;
   expect_t expect_q[$];
   expect_t exp_slot;

   int error_count = 0;
   int check_count = 0;
   int slot_checks = 0;
   int cycle_count = 0;

   renderer #(
      .DISPLAY_WIDTH(DISPLAY_WIDTH),
      .DISPLAY_HEIGHT(DISPLAY_HEIGHT),
      .H_FP(H_FP),
      .H_SYNC(H_SYNC),
      .H_BP(H_BP),
      .V_FP(V_FP),
      .V_SYNC(V_SYNC),
      .V_BP(V_BP)
   ) i_dut (
      .clk_in(clk_in),
      .rst_in(rst_in),
      .data_in(data_in),
      .view_x(view_x),
      .view_y(view_y),
      .cursor_x(cursor_x),
      .cursor_y(cursor_y),
      .addr_out(addr_out),
      .pix_out(pix_out),
      .hsync_out(hsync_out),
      .vsync_out(vsync_out),
      .done_out(done_out)
   );

   tb_board_mem #(
      .DEPTH(256),
      .SEED(MEM_SEED)
   ) i_mem (
      .clk_in(clk_in),
      .addr(addr_out),
      .data(data_in)
   );

   ////////////////////
   // expected pixel
   ////////////////////

   function automatic expect_t reference_pixel(int h, int v, int vx, int vy, int cx, int cy);
      expect_t     e;
      int          bx;
      int          by;
      int          cell_col;
      int          x0;
      int          y0;
      logic        blank;
      logic        cell_on;
      logic        fence_on;
      logic        cursor_on;
      board_word_t word;

      e.h = hcount_t'(h);
      e.v = vcount_t'(v);
      blank = (h >= DISPLAY_WIDTH) || (v >= DISPLAY_HEIGHT);
      e.hsync = !((h >= DISPLAY_WIDTH + H_FP) && (h < DISPLAY_WIDTH + H_FP + H_SYNC));
      e.vsync = !((v >= DISPLAY_HEIGHT + V_FP) && (v < DISPLAY_HEIGHT + V_FP + V_SYNC));
      e.done = (v >= DISPLAY_HEIGHT);

      // board cell under the pixel, wrapping on both axes
      bx = (vx + h / CELL_SIZE) % BOARD_SIZE;
      by = (vy + v / CELL_SIZE) % BOARD_SIZE;
      e.addr = LOG_MAX_ADDR'(by * WORDS_PER_ROW + bx / WORD_SIZE);
      word = i_mem.mem[e.addr];
      cell_col = bx % WORD_SIZE;
      cell_on = word[WORD_SIZE - 1 - cell_col] && (h < VIEW_PIX) && (v < VIEW_PIX);

      fence_on = (h == VIEW_PIX) || ((h > VIEW_PIX) && (v == DISPLAY_HEIGHT / 2));

      // cursor square relative to the view
      x0 = ((cx - vx + BOARD_SIZE) % BOARD_SIZE) * CELL_SIZE;
      y0 = ((cy - vy + BOARD_SIZE) % BOARD_SIZE) * CELL_SIZE;
      cursor_on = (h >= x0) && (h < x0 + CELL_SIZE) && (v >= y0) && (v < y0 + CELL_SIZE)
                  && ((h == x0) || (h == x0 + CELL_SIZE - 1)
                      || (v == y0) || (v == y0 + CELL_SIZE - 1));

      e.pix = '0;
      if (!blank) begin
         if (cell_on) e.pix = e.pix | CELL_COLOR;
         if (fence_on) e.pix = e.pix | FENCE_COLOR;
         if (cursor_on) e.pix = e.pix | CURSOR_COLOR;
      end
      return e;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (expected !== actual) begin
         error_count++;
         $display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
      end
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_in);
      #1;
   endtask

   task automatic set_positions(input pos_t vx, input pos_t vy, input pos_t cx, input pos_t cy);
      view_x = vx;
      view_y = vy;
      cursor_x = cx;
      cursor_y = cy;
   endtask

   initial begin
      clk_in = 1'b0;
      forever #50 clk_in = ~clk_in;
   end

   ////////////////////
   // reference model
   ////////////////////

   always @(posedge clk_in) begin
      if (rst_in) begin
         ref_h = 0;
         ref_v = 0;
         ref_vx = '0;
         ref_vy = '0;
         ref_cx = '0;
         ref_cy = '0;
         expect_q.delete();
      end else begin
         expect_q.push_back(reference_pixel(ref_h, ref_v, ref_vx, ref_vy, ref_cx, ref_cy));
         // positions picked up on the last slot of a frame
         if ((ref_h == H_TOTAL - 1) && (ref_v == V_TOTAL - 1)) begin
            ref_vx = view_x;
            ref_vy = view_y;
            ref_cx = cursor_x;
            ref_cy = cursor_y;
         end
         if (ref_h == H_TOTAL - 1) begin
            ref_h = 0;
            ref_v = (ref_v == V_TOTAL - 1) ? 0 : ref_v + 1;
         end else begin
            ref_h++;
         end
      end
   end

   // outputs sampled mid cycle, four slots behind the raster
   always @(negedge clk_in) begin
      // word address leaves one slot behind the raster
      if (!rst_in && (expect_q.size() > 0)) begin
         check_value($sformatf("addr_out at (%0d,%0d)", expect_q[$].h, expect_q[$].v),
                     expect_q[$].addr, addr_out);
      end
      if (!rst_in && (expect_q.size() >= PIPE_DEPTH)) begin
         exp_slot = expect_q.pop_front();
         slot_checks++;
         check_value($sformatf("pix_out at (%0d,%0d)", exp_slot.h, exp_slot.v),
                     exp_slot.pix, pix_out);
         check_value($sformatf("hsync_out at (%0d,%0d)", exp_slot.h, exp_slot.v),
                     exp_slot.hsync, hsync_out);
         check_value($sformatf("vsync_out at (%0d,%0d)", exp_slot.h, exp_slot.v),
                     exp_slot.vsync, vsync_out);
         check_value($sformatf("done_out at (%0d,%0d)", exp_slot.h, exp_slot.v),
                     exp_slot.done, done_out);
      end
   end

   always @(posedge clk_in) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("SOME TESTS FAILED");
         $finish;
      end
   end

   ////////////////////
   // stimulus
   ////////////////////

   initial begin
      rst_in = 1'b1;
      set_positions(6'd5, 6'd3, 6'd7, 6'd6);
      repeat (3) @(posedge clk_in);
      #1;
      check_value("reset pix_out", 12'h000, pix_out);
      check_value("reset done_out", 1'b1, done_out);
      check_value("reset hsync_out", 1'b1, hsync_out);
      check_value("reset vsync_out", 1'b1, vsync_out);
      rst_in = 1'b0;

      // frame 1 uses cleared positions, frame 2 the view at (5,3)
      wait_cycles(FRAME_CYCLES + FRAME_CYCLES / 2);
      // mid frame 2, wrapping view for frame 3
      set_positions(6'd62, 6'd60, 6'd1, 6'd2);
      wait_cycles(FRAME_CYCLES);
      // mid frame 3, cursor in the last view column for frame 4
      set_positions(6'd5, 6'd3, 6'd20, 6'd10);
      wait_cycles(FRAME_CYCLES + FRAME_CYCLES / 2 + PIPE_DEPTH);

      check_value("compared slots", 4 * FRAME_CYCLES, slot_checks);
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

//--- vga_timing.sv
`timescale 1ns/10ps

module vga_timing
   import life_render_pkg::*;
#(
   parameter int DISPLAY_WIDTH = 640,
   parameter int DISPLAY_HEIGHT = 480,
   parameter int H_FP = 16,
   parameter int H_SYNC = 96,
   parameter int H_BP = 48,
   parameter int V_FP = 11,
   parameter int V_SYNC = 2,
   parameter int V_BP = 31
) (
   input  logic    clk_in,
   input  logic    rst_in,
   output raster_t raster,
   output logic    frame_end
);

   // full line and frame lengths including porches
   localparam int H_TOTAL = DISPLAY_WIDTH + H_FP + H_SYNC + H_BP;
   localparam int V_TOTAL = DISPLAY_HEIGHT + V_FP + V_SYNC + V_BP;

   // sync windows, end is exclusive
   localparam int H_SYNC_START = DISPLAY_WIDTH + H_FP;
   localparam int H_SYNC_END = H_SYNC_START + H_SYNC;
   localparam int V_SYNC_START = DISPLAY_HEIGHT + V_FP;
   localparam int V_SYNC_END = V_SYNC_START + V_SYNC;

   hcount_t hcount;
   vcount_t vcount;
   logic    line_end;
   logic    in_hsync;
   logic    in_vsync;

   assign line_end = (hcount == hcount_t'(H_TOTAL - 1));
   assign frame_end = line_end && (vcount == vcount_t'(V_TOTAL - 1));

   ////////////////////
   // counters
   ////////////////////

   always_ff @(posedge clk_in) begin
      if (rst_in) begin
         hcount <= '0;
         vcount <= '0;
      end else if (line_end) begin
         hcount <= '0;
         vcount <= frame_end ? '0 : vcount + 1'b1;
      end else begin
         hcount <= hcount + 1'b1;
      end
   end

   ////////////////////
   // sync and blank decode
   ////////////////////

   always_comb begin
      in_hsync = (hcount >= hcount_t'(H_SYNC_START)) && (hcount < hcount_t'(H_SYNC_END));
      in_vsync = (vcount >= vcount_t'(V_SYNC_START)) && (vcount < vcount_t'(V_SYNC_END));

      raster.hcount = hcount;
      raster.vcount = vcount;
      // active low syncs
      raster.hsync = !in_hsync;
      raster.vsync = !in_vsync;
      raster.blank = (hcount >= hcount_t'(DISPLAY_WIDTH))
                     || (vcount >= vcount_t'(DISPLAY_HEIGHT));
   end

   // counters stay inside the line and frame
   a_hcount_range: assert property (@(posedge clk_in) disable iff (rst_in)
      hcount < hcount_t'(H_TOTAL));

   a_vcount_range: assert property (@(posedge clk_in) disable iff (rst_in)
      vcount < vcount_t'(V_TOTAL));

endmodule
